// ==== common/mipsPkg.sv ====
`default_nettype none

package mipsPkg;

   localparam int DataWidth = 32;
   localparam int RegAddrWidth = 5;

   //////////////////////////////////////////////////////////////////////
   // Instruction encodings
   //////////////////////////////////////////////////////////////////////
   localparam logic [5:0] OpRType = 6'h00;
   localparam logic [5:0] OpAddi = 6'h08;
   localparam logic [5:0] OpLw = 6'h23;
   localparam logic [5:0] OpSw = 6'h2b;
   localparam logic [5:0] OpBeq = 6'h04;

   // R-type funct field
   localparam logic [5:0] FnAdd = 6'h20;
   localparam logic [5:0] FnSub = 6'h22;
   localparam logic [5:0] FnAnd = 6'h24;
   localparam logic [5:0] FnOr = 6'h25;
   localparam logic [5:0] FnSlt = 6'h2a;

   // Classic MIPS ALU control encoding
   typedef enum logic [2:0] {
      AluAnd = 3'b000,
      AluOr = 3'b001,
      AluAdd = 3'b010,
      AluSub = 3'b110,
      AluSlt = 3'b111
   } aluOpT;

   // Execute operand source
   typedef enum logic [1:0] {
      FwdReg = 2'b00,
      FwdWb = 2'b01,
      FwdMem = 2'b10
   } fwdSelT;

   //////////////////////////////////////////////////////////////////////
   // Stage register payloads
   //////////////////////////////////////////////////////////////////////
   typedef struct packed {
      logic regWrite;
      logic memToReg;
      logic memWrite;
      logic aluSrc;
      logic regDst;
      logic branch;
      aluOpT aluOp;
   } ctrlT;

   typedef struct packed {
      logic [DataWidth-1:0] instr;
      logic [DataWidth-1:0] pcPlus4;
   } ifIdT;

   typedef struct packed {
      ctrlT ctrl;
      logic [DataWidth-1:0] rd1;
      logic [DataWidth-1:0] rd2;
      logic [DataWidth-1:0] signImm;
      logic [RegAddrWidth-1:0] rs;
      logic [RegAddrWidth-1:0] rt;
      logic [RegAddrWidth-1:0] rd;
   } idExT;

   typedef struct packed {
      logic regWrite;
      logic memToReg;
      logic memWrite;
      logic [DataWidth-1:0] aluOut;
      logic [DataWidth-1:0] writeData;
      logic [RegAddrWidth-1:0] writeReg;
   } exMemT;

   typedef struct packed {
      logic regWrite;
      logic memToReg;
      logic [DataWidth-1:0] readData;
      logic [DataWidth-1:0] aluOut;
      logic [RegAddrWidth-1:0] writeReg;
   } memWbT;

endpackage

`default_nettype wire

// ==== rtl/pipeReg.sv ====
`timescale 1ns/1ns
`default_nettype none

// One pipeline stage register, shared by all four stages
module pipeReg #(
   parameter type payloadT = logic [31:0]
) (
   input wire logic clk,
   input wire logic rst,
   input wire logic stall,
   input wire logic flush,
   input wire payloadT d,
   output payloadT q
);

   // Clear beats hold, an all-zero payload is a bubble
   always_ff @(posedge clk) begin
      if (rst || flush) begin
         q <= '0;
      end else if (!stall) begin
         q <= d;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/controlDecode.sv ====
`timescale 1ns/1ns
`default_nettype none

module controlDecode (
   input wire logic [31:0] instr,
   output mipsPkg::ctrlT ctrl,
   output logic isBranch
);

   logic [5:0] opcode;
   logic [5:0] funct;

   assign opcode = instr[31:26];
   assign funct = instr[5:0];

   always_comb begin
      ctrl = '0;
      case (opcode)
         mipsPkg::OpRType: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst = 1'b1;
            case (funct)
               mipsPkg::FnAdd: ctrl.aluOp = mipsPkg::AluAdd;
               mipsPkg::FnSub: ctrl.aluOp = mipsPkg::AluSub;
               mipsPkg::FnAnd: ctrl.aluOp = mipsPkg::AluAnd;
               mipsPkg::FnOr: ctrl.aluOp = mipsPkg::AluOr;
               mipsPkg::FnSlt: ctrl.aluOp = mipsPkg::AluSlt;
               // Shifts and the rest, also the all-zero nop
               default: ctrl = '0;
            endcase
         end
         mipsPkg::OpAddi: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluSrc = 1'b1;
            ctrl.aluOp = mipsPkg::AluAdd;
         end
         mipsPkg::OpLw: begin
            ctrl.regWrite = 1'b1;
            ctrl.memToReg = 1'b1;
            ctrl.aluSrc = 1'b1;
            ctrl.aluOp = mipsPkg::AluAdd;
         end
         mipsPkg::OpSw: begin
            ctrl.memWrite = 1'b1;
            ctrl.aluSrc = 1'b1;
            ctrl.aluOp = mipsPkg::AluAdd;
         end
         // Compare happens in decode, ALU unused
         mipsPkg::OpBeq: ctrl.branch = 1'b1;
         default: ctrl = '0;
      endcase
   end

   assign isBranch = ctrl.branch;

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

module regFile (
   input wire logic clk,
   input wire logic rst,
   input wire logic [4:0] ra1,
   input wire logic [4:0] ra2,
   input wire logic [4:0] wa,
   input wire logic [31:0] wd,
   input wire logic we,
   output logic [31:0] rd1,
   output logic [31:0] rd2
);

   logic [31:0] regs [32];

   // Entry 0 is cleared on reset and never written
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (we && wa != 5'd0) begin
         regs[wa] <= wd;
      end
   end

   // Bypass the write port, same effect as writing in the first half cycle
   assign rd1 = (ra1 == 5'd0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
   assign rd2 = (ra2 == 5'd0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
   input wire logic [mipsPkg::DataWidth-1:0] a,
   input wire logic [mipsPkg::DataWidth-1:0] b,
   input wire mipsPkg::aluOpT op,
   output logic [mipsPkg::DataWidth-1:0] y
);

   always_comb begin
      case (op)
         mipsPkg::AluAdd: y = a + b;
         mipsPkg::AluSub: y = a - b;
         mipsPkg::AluAnd: y = a & b;
         mipsPkg::AluOr: y = a | b;
         // Signed compare
         mipsPkg::AluSlt: y = {{(mipsPkg::DataWidth-1){1'b0}}, $signed(a) < $signed(b)};
         default: y = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== rtl/hazardUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
   input wire logic [mipsPkg::RegAddrWidth-1:0] rsD,
   input wire logic [mipsPkg::RegAddrWidth-1:0] rtD,
   input wire logic branchD,
   input wire mipsPkg::idExT idEx,
   input wire logic [mipsPkg::RegAddrWidth-1:0] writeRegE,
   input wire mipsPkg::exMemT exMem,
   input wire mipsPkg::memWbT memWb,
   output logic stallF,
   output logic stallD,
   output logic flushE,
   output logic forwardAD,
   output logic forwardBD,
   output mipsPkg::fwdSelT forwardAE,
   output mipsPkg::fwdSelT forwardBE
);

   logic lwStall;
   logic branchStall;

   // Memory stage is younger, so it wins over writeback
   function automatic mipsPkg::fwdSelT fwdSel(input logic [4:0] src, input mipsPkg::exMemT m,
                                              input mipsPkg::memWbT w);
      if (src != 5'd0 && m.regWrite && m.writeReg == src) return mipsPkg::FwdMem;
      else if (src != 5'd0 && w.regWrite && w.writeReg == src) return mipsPkg::FwdWb;
      else return mipsPkg::FwdReg;
   endfunction

   assign forwardAE = fwdSel(idEx.rs, exMem, memWb);
   assign forwardBE = fwdSel(idEx.rt, exMem, memWb);

   // Branch operands only take the memory stage ALU result
   assign forwardAD = rsD != 5'd0 && exMem.regWrite && exMem.writeReg == rsD;
   assign forwardBD = rtD != 5'd0 && exMem.regWrite && exMem.writeReg == rtD;

   assign lwStall = idEx.ctrl.memToReg && (idEx.rt == rsD || idEx.rt == rtD);

   // Operand still in the ALU, or a load still in memory
   assign branchStall = branchD &&
      ((idEx.ctrl.regWrite && (writeRegE == rsD || writeRegE == rtD)) ||
       (exMem.memToReg && (exMem.writeReg == rsD || exMem.writeReg == rtD)));

   assign stallF = lwStall || branchStall;
   assign stallD = lwStall || branchStall;
   assign flushE = lwStall || branchStall;

endmodule

`default_nettype wire

// ==== rtl/cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu (
   input wire logic clk,
   input wire logic rst,
   output logic [31:0] instrAddr,
   input wire logic [31:0] instr,
   output logic [31:0] dataAddr,
   output logic [31:0] writeData,
   output logic memWrite,
   input wire logic [31:0] readData
);

   logic [31:0] pcF;
   logic [31:0] pcPlus4F;
   logic stallF;

   mipsPkg::ifIdT ifIdQ;
   mipsPkg::ctrlT ctrlD;
   logic [31:0] instrD;
   logic [4:0] rsD;
   logic [4:0] rtD;
   logic [31:0] rd1D;
   logic [31:0] rd2D;
   logic [31:0] signImmD;
   logic [31:0] pcBranchD;
   logic branchD;
   logic pcSrcD;
   logic stallD;
   logic forwardAD;
   logic forwardBD;

   mipsPkg::idExT idExQ;
   mipsPkg::fwdSelT forwardAE;
   mipsPkg::fwdSelT forwardBE;
   logic [31:0] srcAE;
   logic [31:0] srcBE;
   logic [31:0] writeDataE;
   logic [31:0] aluOutE;
   logic [4:0] writeRegE;
   logic flushE;

   mipsPkg::exMemT exMemQ;
   mipsPkg::memWbT memWbQ;
   logic [31:0] resultW;

   // Three-way operand select for the execute stage
   function automatic logic [31:0] fwdMux(input mipsPkg::fwdSelT sel, input logic [31:0] regVal,
                                          input logic [31:0] wbVal, input logic [31:0] memVal);
      case (sel)
         mipsPkg::FwdWb: return wbVal;
         mipsPkg::FwdMem: return memVal;
         default: return regVal;
      endcase
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Fetch
   //////////////////////////////////////////////////////////////////////
   assign pcPlus4F = pcF + 32'd4;

   always_ff @(posedge clk) begin
      if (rst) begin
         pcF <= '0;
      end else if (!stallF) begin
         pcF <= pcSrcD ? pcBranchD : pcPlus4F;
      end
   end

   assign instrAddr = pcF;

   // Taken branch squashes the instruction fetched behind it
   pipeReg #(.payloadT(mipsPkg::ifIdT)) ifIdReg (
      .clk(clk), .rst(rst), .stall(stallD), .flush(pcSrcD),
      .d('{instr: instr, pcPlus4: pcPlus4F}), .q(ifIdQ)
   );

   //////////////////////////////////////////////////////////////////////
   // Decode
   //////////////////////////////////////////////////////////////////////
   assign instrD = ifIdQ.instr;
   assign rsD = instrD[25:21];
   assign rtD = instrD[20:16];
   assign signImmD = {{16{instrD[15]}}, instrD[15:0]};
   assign pcBranchD = ifIdQ.pcPlus4 + {signImmD[29:0], 2'b00};

   controlDecode ctrlDec (.instr(instrD), .ctrl(ctrlD), .isBranch(branchD));

   regFile rf (
      .clk(clk), .rst(rst), .ra1(rsD), .ra2(rtD),
      .wa(memWbQ.writeReg), .wd(resultW), .we(memWbQ.regWrite),
      .rd1(rd1D), .rd2(rd2D)
   );

   // Compare with stale operands is ignored while stalled
   assign pcSrcD = branchD && !stallD &&
      ((forwardAD ? exMemQ.aluOut : rd1D) == (forwardBD ? exMemQ.aluOut : rd2D));

   pipeReg #(.payloadT(mipsPkg::idExT)) idExReg (
      .clk(clk), .rst(rst), .stall(1'b0), .flush(flushE),
      .d('{ctrl: ctrlD, rd1: rd1D, rd2: rd2D, signImm: signImmD,
           rs: rsD, rt: rtD, rd: instrD[15:11]}),
      .q(idExQ)
   );

   //////////////////////////////////////////////////////////////////////
   // Execute
   //////////////////////////////////////////////////////////////////////
   assign srcAE = fwdMux(forwardAE, idExQ.rd1, resultW, exMemQ.aluOut);
   assign writeDataE = fwdMux(forwardBE, idExQ.rd2, resultW, exMemQ.aluOut);
   assign srcBE = idExQ.ctrl.aluSrc ? idExQ.signImm : writeDataE;
   assign writeRegE = idExQ.ctrl.regDst ? idExQ.rd : idExQ.rt;

   alu aluE (.a(srcAE), .b(srcBE), .op(idExQ.ctrl.aluOp), .y(aluOutE));

   pipeReg #(.payloadT(mipsPkg::exMemT)) exMemReg (
      .clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0),
      .d('{regWrite: idExQ.ctrl.regWrite, memToReg: idExQ.ctrl.memToReg,
           memWrite: idExQ.ctrl.memWrite, aluOut: aluOutE,
           writeData: writeDataE, writeReg: writeRegE}),
      .q(exMemQ)
   );

   //////////////////////////////////////////////////////////////////////
   // Memory and writeback
   //////////////////////////////////////////////////////////////////////
   assign dataAddr = exMemQ.aluOut;
   assign writeData = exMemQ.writeData;
   assign memWrite = exMemQ.memWrite;

   pipeReg #(.payloadT(mipsPkg::memWbT)) memWbReg (
      .clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0),
      .d('{regWrite: exMemQ.regWrite, memToReg: exMemQ.memToReg,
           readData: readData, aluOut: exMemQ.aluOut, writeReg: exMemQ.writeReg}),
      .q(memWbQ)
   );

   assign resultW = memWbQ.memToReg ? memWbQ.readData : memWbQ.aluOut;

   hazardUnit hazard (
      .rsD(rsD), .rtD(rtD), .branchD(branchD), .idEx(idExQ), .writeRegE(writeRegE),
      .exMem(exMemQ), .memWb(memWbQ), .stallF(stallF), .stallD(stallD), .flushE(flushE),
      .forwardAD(forwardAD), .forwardBD(forwardBD),
      .forwardAE(forwardAE), .forwardBE(forwardBE)
   );

endmodule

`default_nettype wire

// ==== verif/tbClock.sv ====
`timescale 1ns/1ns
`default_nettype none

// Free-running clock and a power-on reset
module tbClock #(
   parameter int Period = 100,
   parameter int ResetCycles = 16
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(Period / 2) clk = ~clk;
   end

   // Release lands on a falling edge, away from the sampling edge
   initial begin
      rst = 1'b1;
      repeat (ResetCycles) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

`default_nettype wire

// ==== verif/hazardUnit_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

// Checks on the stall, flush and reset behaviour of the core
module hazardUnitSva (
   input wire logic clk,
   input wire logic rst,
   input wire logic [31:0] instrAddr,
   input wire logic memWrite,
   input wire logic stallF,
   input wire logic flushE,
   input wire mipsPkg::ctrlT idExCtrl
);

   int failCount = 0;

   // A stalled fetch keeps the same PC on the next edge
   stallHoldsPc: assert property (@(posedge clk) disable iff (rst)
      stallF |=> $stable(instrAddr))
      else begin
         $error("PC moved during a fetch stall");
         failCount++;
      end

   // Covers every reset cycle and the first one after release
   quietReset: assert property (@(posedge clk) rst |=> !memWrite)
      else begin
         $error("Store issued during or right after reset");
         failCount++;
      end

   // Flushed execute stage holds a bubble on the next edge
   flushBubble: assert property (@(posedge clk) disable iff (rst)
      flushE |=> idExCtrl == '0)
      else begin
         $error("Execute stage not cleared after a flush");
         failCount++;
      end

endmodule

`default_nettype wire

// ==== verif/cpuTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpuTb;

   localparam int ClkPeriod = 100;
   localparam int ResetCycles = 16;
   // Last store leaves the memory stage within a few cycles of the loop fetch
   localparam int DrainCycles = 6;

   logic clk;
   logic rst;
   logic [31:0] instrAddr;
   logic [31:0] instr;
   logic [31:0] dataAddr;
   logic [31:0] writeData;
   logic memWrite;
   logic [31:0] readData;

   logic [31:0] imem [128];
   string tagMem [128];
   logic [31:0] dmem [64];
   logic [31:0] expAddr [$];
   logic [31:0] expData [$];
   string expName [$];
   logic [31:0] lcgState;
   logic [31:0] loopPc;
   bit built = 1'b0;
   int progLen = 0;
   int storeIdx = 0;
   int storeErrors = 0;
   int missErrors = 0;
   int svaErrors;

   tbClock #(.Period(ClkPeriod), .ResetCycles(ResetCycles)) clkGen (.clk(clk), .rst(rst));

   cpu uut (
      .clk(clk), .rst(rst), .instrAddr(instrAddr), .instr(instr),
      .dataAddr(dataAddr), .writeData(writeData), .memWrite(memWrite), .readData(readData)
   );

   bind hazardUnit hazardUnitSva svaChk (
      .clk(cpuTb.clk), .rst(cpuTb.rst), .instrAddr(cpuTb.instrAddr),
      .memWrite(exMem.memWrite), .stallF(stallF), .flushE(flushE), .idExCtrl(idEx.ctrl)
   );

   assign instr = imem[instrAddr[8:2]];
   assign readData = dmem[dataAddr[7:2]];

   function automatic logic [31:0] lcgNext(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Every byte address bit shows up in the word
   function automatic logic [31:0] fillWord(input logic [31:0] addr);
      return (addr * 32'h0101_0101) ^ 32'h5a3c_96e1;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Program assembly
   //////////////////////////////////////////////////////////////////////
   task automatic emit(input logic [31:0] word, input string name);
      imem[progLen] = word;
      tagMem[progLen] = name;
      progLen++;
   endtask

   task automatic emitR(input logic [5:0] fn, input int rd, input int rs, input int rt);
      emit({mipsPkg::OpRType, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn}, "");
   endtask

   task automatic emitI(input logic [5:0] op, input int rt, input int rs, input logic [15:0] imm);
      emit({op, rs[4:0], rt[4:0], imm}, "");
   endtask

   task automatic emitSw(input int rt, input logic [15:0] addr, input string name);
      emit({mipsPkg::OpSw, 5'd0, rt[4:0], addr}, name);
   endtask

   task automatic buildProgram();
      for (int i = 0; i < 128; i++) begin
         imem[i] = '0;
         tagMem[i] = "";
      end
      lcgState = 32'ha998;
      for (int r = 1; r <= 8; r++) begin
         lcgState = lcgNext(lcgState);
         emitI(mipsPkg::OpAddi, r, 0, lcgState[31:16]);
      end
      // ALU operations
      emitR(mipsPkg::FnAdd, 9, 1, 2);
      emitSw(9, 16'h0080, "aluAdd");
      emitR(mipsPkg::FnSub, 10, 3, 4);
      emitSw(10, 16'h0084, "aluSub");
      emitR(mipsPkg::FnAnd, 11, 5, 6);
      emitSw(11, 16'h0088, "aluAnd");
      emitR(mipsPkg::FnOr, 12, 7, 8);
      emitSw(12, 16'h008c, "aluOr");
      emitR(mipsPkg::FnSlt, 13, 1, 2);
      emitSw(13, 16'h0090, "aluSltAB");
      emitR(mipsPkg::FnSlt, 14, 2, 1);
      emitSw(14, 16'h0094, "aluSltBA");
      emitI(mipsPkg::OpAddi, 15, 3, lcgState[15:0]);
      emitSw(15, 16'h0098, "aluAddi");
      // Forwarding chains, distance 1, 2 and 3
      emitR(mipsPkg::FnAdd, 16, 1, 2);
      emitR(mipsPkg::FnAdd, 17, 16, 3);
      emitR(mipsPkg::FnAdd, 18, 16, 17);
      emitSw(18, 16'h009c, "fwdMemWb");
      emitSw(17, 16'h00a0, "fwdWbStore");
      emitR(mipsPkg::FnAdd, 19, 4, 5);
      emitR(mipsPkg::FnAnd, 20, 6, 7);
      emitR(mipsPkg::FnOr, 21, 8, 1);
      emitR(mipsPkg::FnSub, 22, 19, 20);
      emitSw(22, 16'h00a4, "fwdRegFile");
      // Load-use
      emitI(mipsPkg::OpLw, 23, 0, 16'h0000);
      emitR(mipsPkg::FnAdd, 24, 23, 1);
      emitSw(24, 16'h00a8, "loadUseAlu");
      emitI(mipsPkg::OpLw, 25, 0, 16'h0004);
      emitSw(25, 16'h00ac, "loadUseStore");
      emitI(mipsPkg::OpLw, 26, 0, 16'h0080);
      emitSw(26, 16'h00b0, "loadStored");
      // Branches, each skipped store must never appear
      emitI(mipsPkg::OpBeq, 0, 0, 16'h0001);
      emitSw(1, 16'h00f0, "branchSkip");
      emitSw(2, 16'h00b4, "branchTaken");
      emitI(mipsPkg::OpAddi, 27, 0, 16'h0005);
      emitI(mipsPkg::OpAddi, 28, 0, 16'h0006);
      emitI(mipsPkg::OpBeq, 28, 27, 16'h0001);
      emitSw(27, 16'h00b8, "branchNotTaken");
      emitI(mipsPkg::OpAddi, 29, 27, 16'h0001);
      emitI(mipsPkg::OpBeq, 28, 29, 16'h0001);
      emitSw(3, 16'h00f4, "branchSkip");
      emitSw(29, 16'h00bc, "branchAfterAlu");
      emitI(mipsPkg::OpLw, 30, 0, 16'h00b8);
      emitI(mipsPkg::OpBeq, 27, 30, 16'h0001);
      emitSw(4, 16'h00f8, "branchSkip");
      emitSw(30, 16'h00c0, "branchAfterLoad");
      // Register 0 ignores writes
      emitI(mipsPkg::OpAddi, 0, 0, 16'h0123);
      emitSw(0, 16'h00c4, "reg0Addi");
      emitR(mipsPkg::FnAdd, 0, 1, 2);
      emitSw(0, 16'h00c8, "reg0Add");
      loopPc = progLen * 4;
      emitI(mipsPkg::OpBeq, 0, 0, 16'hffff);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Architectural model, one instruction per step
   //////////////////////////////////////////////////////////////////////
   task automatic runModel();
      logic [31:0] regs [32];
      logic [31:0] modelMem [64];
      logic [31:0] pc;
      logic [31:0] word;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      logic [31:0] ea;
      int steps;
      for (int i = 0; i < 32; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < 64; i++) begin
         modelMem[i] = fillWord(i * 4);
      end
      pc = '0;
      steps = 0;
      while (pc != loopPc && steps < 1000) begin
         word = imem[pc[8:2]];
         a = regs[word[25:21]];
         b = regs[word[20:16]];
         imm = {{16{word[15]}}, word[15:0]};
         ea = a + imm;
         case (word[31:26])
            mipsPkg::OpRType: begin
               case (word[5:0])
                  mipsPkg::FnAdd: regs[word[15:11]] = a + b;
                  mipsPkg::FnSub: regs[word[15:11]] = a - b;
                  mipsPkg::FnAnd: regs[word[15:11]] = a & b;
                  mipsPkg::FnOr: regs[word[15:11]] = a | b;
                  mipsPkg::FnSlt: regs[word[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                  default: ;
               endcase
            end
            mipsPkg::OpAddi: regs[word[20:16]] = ea;
            mipsPkg::OpLw: regs[word[20:16]] = modelMem[ea[7:2]];
            mipsPkg::OpSw: begin
               modelMem[ea[7:2]] = b;
               expAddr.push_back(ea);
               expData.push_back(b);
               expName.push_back(tagMem[pc[8:2]]);
            end
            default: ;
         endcase
         // Branch offset counts words from the next instruction
         if (word[31:26] == mipsPkg::OpBeq && a == b) begin
            pc = pc + 32'd4 + {imm[29:0], 2'b00};
         end else begin
            pc = pc + 32'd4;
         end
         regs[0] = '0;
         steps++;
      end
   endtask

   // Data memory, stores land mid-cycle
   initial begin
      for (int i = 0; i < 64; i++) begin
         dmem[i] = fillWord(i * 4);
      end
      forever begin
         @(negedge clk);
         if (!rst && memWrite) begin
            if (storeIdx >= expAddr.size()) begin
               $display("Unexpected store of %h to address %h after the last expected one",
                        writeData, dataAddr);
               storeErrors++;
            end else begin
               assert (dataAddr == expAddr[storeIdx] && writeData == expData[storeIdx])
               else begin
                  $display("[FAIL] %s: expected %h at %h, actual %h at %h", expName[storeIdx],
                           expData[storeIdx], expAddr[storeIdx], writeData, dataAddr);
                  storeErrors++;
               end
               storeIdx++;
            end
            dmem[dataAddr[7:2]] = writeData;
         end
      end
   end

   initial begin
      buildProgram();
      runModel();
      built = 1'b1;
      @(negedge clk);
      while (rst || instrAddr != loopPc) begin
         @(negedge clk);
      end
      repeat (DrainCycles) @(negedge clk);
      assert (storeIdx == expAddr.size())
      else begin
         $display("Only %0d of %0d expected stores were seen", storeIdx, expAddr.size());
         missErrors++;
      end
      svaErrors = uut.hazard.svaChk.failCount;
      $display("Stores checked %0d, store errors %0d, missing stores %0d, assertion errors %0d",
               storeIdx, storeErrors, missErrors, svaErrors);
      if (storeErrors + missErrors + svaErrors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // Generous bound, five cycles per instruction after reset
   initial begin
      wait (built);
      #((ResetCycles + 5 * progLen) * ClkPeriod);
      $display("Timeout, the core never reached the end-of-program loop");
      $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
common/mipsPkg.sv
rtl/pipeReg.sv
rtl/controlDecode.sv
rtl/regFile.sv
rtl/alu.sv
rtl/hazardUnit.sv
rtl/cpu.sv
verif/tbClock.sv
verif/hazardUnit_sva.sv
verif/cpuTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module cpuTb -f build.f -o cpuSim

./obj_dir/cpuSim +verilator+error+limit+1000 | tee sim.log

if grep -qx "Regression passed" sim.log; then
   exit 0
fi
exit 1
